// ==== decodeStage.sv ====
// one decode register stage; the group is held, not dropped, while fetch is stalled, and flush wins over load.
`timescale 1ns/1ps

module decodeStage (
  input  logic                               clk,
  input  logic                               rstN_i,
  input  logic                               flush_i,          // misprediction, empties the stage.
  input  logic [fetchPkg::FETCH_WIDTH-1:0]   fetchValid_i,     // per lane valid.
  input  fetchPkg::rawGroup_t                fetchGroup_i,
  input  logic                               stallFetch_i,     // buffer near full.
  output logic                               decodeReady_o,    // a group sits in the register.
  output logic [fetchPkg::FETCH_WIDTH-1:0]   decodedVector_o,
  output fetchPkg::decodedGroup_t            decodedGroup_o
);

  fetchPkg::decodedGroup_t decodedNext;  // combinational decode of the incoming lanes.
  logic                    loadGroup;    // register takes the input this edge.

  // split every lane, valid or not; the vector masks the rest.
  always_comb begin : splitLanes
    for (int i = 0; i < fetchPkg::FETCH_WIDTH; i++) begin
      decodedNext[i] = fetchPkg::decodeInst(fetchGroup_i[i]);
    end
  end

  // a stalled buffer has not written the held group yet.
  assign loadGroup = ~stallFetch_i;

  // control half of the register.
  always_ff @(posedge clk) begin
    if (!rstN_i || flush_i) begin
      decodeReady_o   <= 1'b0;
      decodedVector_o <= '0;
    end else if (loadGroup) begin
      // the old group was written this edge, so replace or clear it.
      decodeReady_o   <= |fetchValid_i;  // an empty vector is not a group.
      decodedVector_o <= fetchValid_i;
    end
  end

  // payload half, no reset needed.
  always_ff @(posedge clk) begin
    if (loadGroup) begin
      decodedGroup_o <= decodedNext;
    end
  end

  // the buffer trusts decodeReady to mean at least one lane is written.
  readyHasLanes: assert property (
    @(posedge clk) disable iff (!rstN_i)
    decodeReady_o |-> (decodedVector_o != '0)
  ) else $error("decodeReady high with an empty lane vector");

endmodule

// ==== dispatchStage.sv ====
// dispatch register; valid is a one-cycle mark per dispatched group and the packets hold their last value.
`timescale 1ns/1ps

module dispatchStage (
  input  logic                     clk,
  input  logic                     rstN_i,
  input  logic                     flush_i,
  input  logic                     dispatch_i,       // buffer advances its head this edge.
  input  fetchPkg::dispatchGroup_t headGroup_i,
  output logic                     dispatchValid_o,
  output fetchPkg::dispatchGroup_t dispatchGroup_o,
  output fetchPkg::branchCount_t   branchCount_o     // branches among the four packets.
);

  fetchPkg::branchCount_t branchSum;  // combinational count at the head.

  // true count, 0 to 4.
  always_comb begin : countBranches
    branchSum = '0;
    for (int i = 0; i < fetchPkg::DISPATCH_WIDTH; i++) begin
      branchSum = branchSum + fetchPkg::branchCount_t'(headGroup_i[i].isBranch);
    end
  end

  // control: valid and count go together.
  always_ff @(posedge clk) begin
    if (!rstN_i || flush_i) begin
      dispatchValid_o <= 1'b0;
      branchCount_o   <= '0;
    end else if (dispatch_i) begin
      dispatchValid_o <= 1'b1;
      branchCount_o   <= branchSum;
    end else begin
      dispatchValid_o <= 1'b0;  // bubble on stall or empty queue.
      branchCount_o   <= '0;
    end
  end

  // packets, loaded only on a pulse.
  always_ff @(posedge clk) begin
    if (dispatch_i) begin
      dispatchGroup_o <= headGroup_i;
    end
  end

  // the back end reads the count only with valid.
  countNeedsValid: assert property (
    @(posedge clk) disable iff (!rstN_i)
    !dispatchValid_o |-> (branchCount_o == '0)
  ) else $error("branch count %0d without a valid group", branchCount_o);

endmodule

// ==== fetchPkg.sv ====
// shared sizes and packet types; the queue size must stay a power of two and hold STALL_LEVEL plus one full group.
package fetchPkg;

  // lane and queue geometry.
  localparam int FETCH_WIDTH    = 8;   // decode lanes per cycle.
  localparam int DISPATCH_WIDTH = 4;   // packets leaving per dispatch.
  localparam int INST_QUEUE     = 32;  // queue entries.
  localparam int INST_QUEUE_LOG = 5;   // pointer width.
  localparam int INST_COUNT_W   = INST_QUEUE_LOG + 1;  // occupancy counts up to INST_QUEUE.
  localparam int LANE_COUNT_W   = $clog2(FETCH_WIDTH + 1);  // 0 to 8 written lanes.
  localparam int COUNT_W        = 3;   // branch count, 0 to 4.

  // fetch stalls above this, so a full group always fits.
  localparam int STALL_LEVEL = INST_QUEUE - 2 * DISPATCH_WIDTH;

  // instruction field widths.
  localparam int PC_W     = 16;
  localparam int WORD_W   = 32;
  localparam int OPCODE_W = 6;
  localparam int REG_W    = 5;
  localparam int IMM_W    = 16;
  localparam int TYPE_W   = 5;

  typedef logic [INST_QUEUE_LOG-1:0] qPtr_t;
  typedef logic [INST_COUNT_W-1:0]   qCount_t;
  typedef logic [LANE_COUNT_W-1:0]   laneCount_t;
  typedef logic [COUNT_W-1:0]        branchCount_t;

  // raw fetched instruction, 48 bits.
  typedef struct packed {
    logic [PC_W-1:0]   pc;
    logic [WORD_W-1:0] word;
  } rawInst_t;

  // decoded packet, 59 bits.
  typedef struct packed {
    logic [PC_W-1:0]     pc;
    logic [OPCODE_W-1:0] opcode;    // word[31:26].
    logic [REG_W-1:0]    src1;      // word[25:21].
    logic [REG_W-1:0]    src2;      // word[20:16].
    logic [REG_W-1:0]    dest;      // word[15:11].
    logic [IMM_W-1:0]    imm;       // word[15:0].
    logic                isBranch;  // both top opcode bits set.
    logic [TYPE_W-1:0]   instType;  // low opcode bits.
  } decodedInst_t;

  typedef rawInst_t     [FETCH_WIDTH-1:0]    rawGroup_t;
  typedef decodedInst_t [FETCH_WIDTH-1:0]    decodedGroup_t;
  typedef decodedInst_t [DISPATCH_WIDTH-1:0] dispatchGroup_t;

  // field split of one instruction word.
  function automatic decodedInst_t decodeInst(rawInst_t raw);
    decodedInst_t d;
    d.pc       = raw.pc;
    d.opcode   = raw.word[31:26];
    d.src1     = raw.word[25:21];
    d.src2     = raw.word[20:16];
    d.dest     = raw.word[15:11];
    d.imm      = raw.word[15:0];
    d.isBranch = &raw.word[31:30];  // opcodes 6'b11xxxx are control transfers.
    d.instType = raw.word[30:26];
    return d;
  endfunction

endpackage

// ==== frontEnd.sv ====
// decode to dispatch front end; flush and reset both empty every stage in one edge.
`timescale 1ns/1ps

module frontEnd (
  input  logic                             clk,
  input  logic                             rstN_i,
  input  logic                             flush_i,          // misprediction.
  input  logic                             backStall_i,      // back end full.
  input  logic [fetchPkg::FETCH_WIDTH-1:0] fetchValid_i,
  input  fetchPkg::rawGroup_t              fetchGroup_i,
  output logic                             fetchStall_o,     // input group not taken while high.
  output logic                             dispatchValid_o,
  output fetchPkg::dispatchGroup_t         dispatchGroup_o,
  output fetchPkg::branchCount_t           branchCount_o
);

  logic                             decodeReady;      // decode register holds a group.
  logic [fetchPkg::FETCH_WIDTH-1:0] decodedVector;
  fetchPkg::decodedGroup_t          decodedGroup;
  logic                             dispatch;         // one decision for buffer and dispatch.
  fetchPkg::dispatchGroup_t         headGroup;

  decodeStage u_decodeStage (
    .clk             (clk),
    .rstN_i          (rstN_i),
    .flush_i         (flush_i),
    .fetchValid_i    (fetchValid_i),
    .fetchGroup_i    (fetchGroup_i),
    .stallFetch_i    (fetchStall_o),
    .decodeReady_o   (decodeReady),
    .decodedVector_o (decodedVector),
    .decodedGroup_o  (decodedGroup)
  );

  // ready is folded into the dispatch pulse inside the buffer.
  instructionBuffer u_instructionBuffer (
    .clk               (clk),
    .rstN_i            (rstN_i),
    .flush_i           (flush_i),
    .backStall_i       (backStall_i),
    .decodeReady_i     (decodeReady),
    .decodedVector_i   (decodedVector),
    .decodedGroup_i    (decodedGroup),
    .stallFetch_o      (fetchStall_o),
    .instBufferReady_o (),
    .dispatch_o        (dispatch),
    .headGroup_o       (headGroup)
  );

  dispatchStage u_dispatchStage (
    .clk             (clk),
    .rstN_i          (rstN_i),
    .flush_i         (flush_i),
    .dispatch_i      (dispatch),
    .headGroup_i     (headGroup),
    .dispatchValid_o (dispatchValid_o),
    .dispatchGroup_o (dispatchGroup_o),
    .branchCount_o   (branchCount_o)
  );

endmodule

// ==== frontEndChecker.sv ====
// checker; samples at the falling edge, and assumes every test drains to an empty queue before its last cycle.
`timescale 1ns/1ps

module frontEndChecker (
  input  logic                             clk,
  input  logic                             rstN_i,
  input  logic                             flush_i,
  input  logic [fetchPkg::FETCH_WIDTH-1:0] fetchValid_i,
  input  fetchPkg::rawGroup_t              fetchGroup_i,
  input  logic                             fetchStall_i,
  input  logic                             dispatchValid_i,
  input  fetchPkg::dispatchGroup_t         dispatchGroup_i,
  input  fetchPkg::branchCount_t           branchCount_i,
  input  fetchPkg::qCount_t                queueCount_i,   // dut occupancy, for leftovers.
  input  logic [3:0]                       testNum_i,
  input  logic                             testEnd_i,      // last cycle of a test.
  output int                               errorCount_o,
  output int                               testsRun_o,
  output int                               testsFailed_o
);

  fetchPkg::decodedInst_t model [$];  // accepted, not yet dispatched, oldest first.
  int testErrors;
  int testGroups;
  int errorCount;
  int testsRun;
  int testsFailed;

  assign errorCount_o  = errorCount;
  assign testsRun_o    = testsRun;
  assign testsFailed_o = testsFailed;

  // expected packet, straight from the field layout.
  function automatic fetchPkg::decodedInst_t expectedPacket(input fetchPkg::rawInst_t raw);
    fetchPkg::decodedInst_t p;
    p.pc       = raw.pc;
    p.opcode   = raw.word[31:26];
    p.src1     = raw.word[25:21];
    p.src2     = raw.word[20:16];
    p.dest     = raw.word[15:11];
    p.imm      = raw.word[15:0];
    p.isBranch = raw.word[31] & raw.word[30];  // opcode 11xxxx.
    p.instType = raw.word[30:26];
    return p;
  endfunction

  // one visible dispatch pops four model entries.
  task automatic checkDispatch();
    fetchPkg::decodedInst_t expected;
    int branches;
    branches = 0;
    testGroups++;
    if (model.size() < fetchPkg::DISPATCH_WIDTH) begin
      $display("%0t: group dispatched with only %0d instructions outstanding",
               $time, model.size());
      testErrors++;
      model.delete();
    end else begin
      for (int j = 0; j < fetchPkg::DISPATCH_WIDTH; j++) begin
        expected = model.pop_front();
        branches += int'(expected.isBranch);
        if (dispatchGroup_i[j] !== expected) begin
          $display("Mismatch at %0t: dispatchGroup_o[%0d] = %h, expected %h",
                   $time, j, dispatchGroup_i[j], expected);
          testErrors++;
        end
      end
      if (branchCount_i !== fetchPkg::branchCount_t'(branches)) begin
        $display("Mismatch at %0t: branchCount_o = %0d, expected %0d",
                 $time, branchCount_i, branches);
        testErrors++;
      end
    end
  endtask

  task automatic reportTest();
    if (model.size() != 0) begin
      $display("test %0d ended with %0d instructions never dispatched", testNum_i, model.size());
      testErrors++;
      model.delete();  // keep the next test clean.
    end
    if (queueCount_i != '0) begin
      $display("test %0d left %0d entries in the queue", testNum_i, queueCount_i);
      testErrors++;
    end
    if (testErrors == 0) begin
      $display("test %0d: ok, %0d groups checked", testNum_i, testGroups);
    end else begin
      $display("test %0d: FAILED with %0d errors", testNum_i, testErrors);
      testsFailed++;
    end
    testsRun++;
    errorCount += testErrors;
    testErrors = 0;
    testGroups = 0;
  endtask

  // falling edge: outputs show the last rising edge, inputs show the next one.
  always @(negedge clk) begin : watchDut
    if (!rstN_i) begin
      model.delete();
      if (fetchStall_i || dispatchValid_i || branchCount_i != '0) begin
        $display("%0t: outputs not cleared during reset", $time);
        testErrors++;
      end
    end else begin
      // the model never holds fewer entries than the dut queue.
      if (fetchStall_i && model.size() <= fetchPkg::STALL_LEVEL) begin
        $display("%0t: fetchStall_o high with only %0d instructions outstanding",
                 $time, model.size());
        testErrors++;
      end
      // no group on the output, so no branches either.
      if (!dispatchValid_i && branchCount_i != '0) begin
        $display("Mismatch at %0t: branchCount_o = %0d, expected 0", $time, branchCount_i);
        testErrors++;
      end
      if (dispatchValid_i) checkDispatch();  // pop before a flush empties the model.
      if (flush_i) begin
        model.delete();  // decode, queue and dispatch all dropped.
      end else if (!fetchStall_i) begin
        for (int i = 0; i < fetchPkg::FETCH_WIDTH; i++) begin
          if (fetchValid_i[i]) model.push_back(expectedPacket(fetchGroup_i[i]));
        end
      end
      if (testEnd_i) reportTest();
    end
  end

endmodule

// ==== frontEndTb.sv ====
// testbench top; table driven, inputs change 10 ns after the rising edge, each test ends drained.
`timescale 1ns/1ps

module frontEndTb;

  // one table row, applied for a number of accepted cycles.
  typedef struct packed {
    logic [3:0] testNum;
    logic [7:0] valid;     // lane valid vector.
    logic [7:0] brMask;    // lanes forced to a branch opcode.
    logic       forceOp;   // other lanes forced to a non-branch.
    logic       flush;
    logic       backStall;
    logic [4:0] cycles;
    logic       last;      // final row of its test.
  } stimRow_t;

  localparam int NUM_ROWS  = 22;
  localparam int NUM_TESTS = 6;

  stimRow_t stimTable [NUM_ROWS] = '{
    // test  valid  brMask force flush bStall cycles last
    '{4'd1, 8'h00, 8'h00, 1'b0, 1'b0, 1'b0, 5'd4,  1'b1},  // idle after reset.
    '{4'd2, 8'hFF, 8'h00, 1'b0, 1'b0, 1'b0, 5'd6,  1'b0},  // full groups, in order.
    '{4'd2, 8'h00, 8'h00, 1'b0, 1'b0, 1'b0, 5'd12, 1'b1},
    '{4'd3, 8'hA5, 8'h00, 1'b0, 1'b0, 1'b0, 5'd1,  1'b0},  // holes get compacted.
    '{4'd3, 8'h0F, 8'h00, 1'b0, 1'b0, 1'b0, 5'd1,  1'b0},
    '{4'd3, 8'h81, 8'h00, 1'b0, 1'b0, 1'b0, 5'd1,  1'b0},
    '{4'd3, 8'h18, 8'h00, 1'b0, 1'b0, 1'b0, 5'd1,  1'b0},
    '{4'd3, 8'h7E, 8'h00, 1'b0, 1'b0, 1'b0, 5'd1,  1'b0},
    '{4'd3, 8'h03, 8'h00, 1'b0, 1'b0, 1'b0, 5'd1,  1'b0},
    '{4'd3, 8'h00, 8'h00, 1'b0, 1'b0, 1'b0, 5'd6,  1'b1},
    '{4'd4, 8'hFF, 8'h00, 1'b0, 1'b0, 1'b1, 5'd5,  1'b0},  // fill under back stall.
    '{4'd4, 8'h00, 8'h00, 1'b0, 1'b0, 1'b1, 5'd3,  1'b0},
    '{4'd4, 8'h00, 8'h00, 1'b0, 1'b0, 1'b0, 5'd16, 1'b1},
    '{4'd5, 8'hFF, 8'h00, 1'b0, 1'b0, 1'b0, 5'd3,  1'b0},  // flush mid-stream.
    '{4'd5, 8'hFF, 8'h00, 1'b0, 1'b1, 1'b0, 5'd1,  1'b0},
    '{4'd5, 8'hFF, 8'h00, 1'b0, 1'b0, 1'b0, 5'd2,  1'b0},
    '{4'd5, 8'h00, 8'h00, 1'b0, 1'b0, 1'b0, 5'd8,  1'b1},
    '{4'd6, 8'hFF, 8'h00, 1'b1, 1'b0, 1'b0, 5'd1,  1'b0},  // branch counts 0 and 0.
    '{4'd6, 8'hFF, 8'h1F, 1'b1, 1'b0, 1'b0, 5'd1,  1'b0},  // 4 and 1.
    '{4'd6, 8'hFF, 8'hE6, 1'b1, 1'b0, 1'b0, 5'd1,  1'b0},  // 2 and 3.
    '{4'd6, 8'hFF, 8'h00, 1'b0, 1'b0, 1'b0, 5'd2,  1'b0},
    '{4'd6, 8'h00, 8'h00, 1'b0, 1'b0, 1'b0, 5'd10, 1'b1}
  };

  bit                             clk;  // two-state, no edge at time zero.
  logic                           rstN_i;
  logic                           flush_i;
  logic                           backStall_i;
  logic [fetchPkg::FETCH_WIDTH-1:0] fetchValid_i;
  fetchPkg::rawGroup_t            fetchGroup_i;
  logic                           fetchStall_o;
  logic                           dispatchValid_o;
  fetchPkg::dispatchGroup_t       dispatchGroup_o;
  fetchPkg::branchCount_t         branchCount_o;
  logic [3:0]                     testNum;
  logic                           testEnd;
  logic [31:0]                    lcgState;
  logic [15:0]                    pcNext;
  int                             errorCount;
  int                             testsRun;
  int                             testsFailed;

  frontEnd u_frontEnd (
    .clk(clk), .rstN_i(rstN_i), .flush_i(flush_i), .backStall_i(backStall_i),
    .fetchValid_i(fetchValid_i), .fetchGroup_i(fetchGroup_i), .fetchStall_o(fetchStall_o),
    .dispatchValid_o(dispatchValid_o), .dispatchGroup_o(dispatchGroup_o),
    .branchCount_o(branchCount_o)
  );

  frontEndChecker u_checker (
    .clk(clk), .rstN_i(rstN_i), .flush_i(flush_i), .fetchValid_i(fetchValid_i),
    .fetchGroup_i(fetchGroup_i), .fetchStall_i(fetchStall_o),
    .dispatchValid_i(dispatchValid_o), .dispatchGroup_i(dispatchGroup_o),
    .branchCount_i(branchCount_o), .queueCount_i(u_frontEnd.u_instructionBuffer.instCount),
    .testNum_i(testNum), .testEnd_i(testEnd), .errorCount_o(errorCount),
    .testsRun_o(testsRun), .testsFailed_o(testsFailed)
  );

  function automatic logic [31:0] lcgNext(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // fresh words for one row cycle; pcs run on across lanes.
  task automatic buildGroup(input stimRow_t row);
    for (int i = 0; i < fetchPkg::FETCH_WIDTH; i++) begin
      lcgState = lcgNext(lcgState);
      fetchGroup_i[i].pc   = pcNext;
      fetchGroup_i[i].word = lcgState;
      if (row.brMask[i]) fetchGroup_i[i].word[31:30] = 2'b11;
      else if (row.forceOp) fetchGroup_i[i].word[31] = 1'b0;
      pcNext = pcNext + 16'd1;
    end
  endtask

  initial begin : clockGen
    forever #50 clk = ~clk;  // 100 ns period.
  end

  initial begin : driveStimulus
    logic held;
    rstN_i       = 1'b0;
    flush_i      = 1'b0;
    backStall_i  = 1'b0;
    fetchValid_i = '0;
    fetchGroup_i = '0;
    testNum      = 4'd0;
    testEnd      = 1'b0;
    lcgState     = 32'h52a45bd4;
    pcNext       = 16'h1000;
    repeat (8) @(posedge clk);
    #10 rstN_i = 1'b1;
    for (int r = 0; r < NUM_ROWS; r++) begin
      for (int c = 0; c < int'(stimTable[r].cycles); c++) begin
        buildGroup(stimTable[r]);
        fetchValid_i = stimTable[r].valid;
        flush_i      = stimTable[r].flush;
        backStall_i  = stimTable[r].backStall;
        testNum      = stimTable[r].testNum;
        testEnd      = stimTable[r].last && (c == int'(stimTable[r].cycles) - 1);
        held         = 1'b1;
        while (held) begin
          @(negedge clk);  // stall here is the level the next edge sees.
          held = fetchStall_o && (|stimTable[r].valid) && !stimTable[r].flush;
          @(posedge clk);
          #10;
        end
      end
    end
    testEnd      = 1'b0;
    fetchValid_i = '0;
    flush_i      = 1'b0;
    backStall_i  = 1'b0;
    $display("tests run %0d of %0d, failed %0d, errors %0d",
             testsRun, NUM_TESTS, testsFailed, errorCount);
    if (testsRun == NUM_TESTS && testsFailed == 0 && errorCount == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  // each row cycle may repeat under stall, so allow four per row cycle.
  initial begin : watchdog
    int limit;
    limit = 0;
    for (int r = 0; r < NUM_ROWS; r++) begin
      limit += int'(stimTable[r].cycles);
    end
    limit = limit * 4 + 200;
    repeat (limit + 8) @(posedge clk);
    $display("timeout: the run did not finish within %0d cycles", limit);
    $display("Some tests failed");
    $finish;
  end

endmodule

// ==== instructionBuffer.sv ====
// 32-entry instruction queue; dispatch only takes whole groups of four, fewer waiting entries stay put.
`timescale 1ns/1ps

module instructionBuffer (
  input  logic                             clk,
  input  logic                             rstN_i,
  input  logic                             flush_i,           // drops every queued entry.
  input  logic                             backStall_i,       // back end cannot take a group.
  input  logic                             decodeReady_i,
  input  logic [fetchPkg::FETCH_WIDTH-1:0] decodedVector_i,
  input  fetchPkg::decodedGroup_t          decodedGroup_i,
  output logic                             stallFetch_o,      // depends on the count only.
  output logic                             instBufferReady_o, // four or more waiting.
  output logic                             dispatch_o,        // head moves this edge.
  output fetchPkg::dispatchGroup_t         headGroup_o
);

  fetchPkg::qPtr_t                  headPtr;     // oldest entry.
  fetchPkg::qPtr_t                  tailPtr;     // next free slot.
  fetchPkg::qCount_t                instCount;   // waiting entries, 0 to 32.
  fetchPkg::qCount_t                countNext;
  logic [fetchPkg::FETCH_WIDTH-1:0] writeEnable;
  fetchPkg::laneCount_t             writeCount;  // lanes written this edge.

  // above STALL_LEVEL the next group of eight might not fit.
  assign stallFetch_o = instCount > fetchPkg::qCount_t'(fetchPkg::STALL_LEVEL);

  // valid lanes of a present group, while there is room.
  assign writeEnable =
    decodedVector_i & {fetchPkg::FETCH_WIDTH{decodeReady_i & ~stallFetch_o}};

  always_comb begin : countWrites
    writeCount = '0;
    for (int i = 0; i < fetchPkg::FETCH_WIDTH; i++) begin
      writeCount = writeCount + fetchPkg::laneCount_t'(writeEnable[i]);
    end
  end

  // read side.
  assign instBufferReady_o = instCount >= fetchPkg::qCount_t'(fetchPkg::DISPATCH_WIDTH);
  assign dispatch_o        = instBufferReady_o & ~backStall_i;  // shared with the dispatch stage.

  // occupancy after this edge's writes and read.
  always_comb begin : nextOccupancy
    countNext = instCount + fetchPkg::qCount_t'(writeCount);
    if (dispatch_o) begin
      countNext = countNext - fetchPkg::qCount_t'(fetchPkg::DISPATCH_WIDTH);
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN_i || flush_i) begin
      headPtr   <= '0;
      tailPtr   <= '0;
      instCount <= '0;
    end else begin
      tailPtr   <= tailPtr + fetchPkg::qPtr_t'(writeCount);  // compacted, so only the sum matters.
      instCount <= countNext;
      if (dispatch_o) begin
        headPtr <= headPtr + fetchPkg::qPtr_t'(fetchPkg::DISPATCH_WIDTH);
      end
    end
  end

  queueRam u_queueRam (
    .clk           (clk),
    .writeEnable_i (writeEnable),
    .writeAddr_i   (tailPtr),
    .writeData_i   (decodedGroup_i),
    .readAddr_i    (headPtr),
    .readData_o    (headGroup_o)
  );

  // the stall threshold plus one group must never overrun the queue.
  countBound: assert property (
    @(posedge clk) disable iff (!rstN_i)
    instCount <= fetchPkg::qCount_t'(fetchPkg::INST_QUEUE)
  ) else $error("instruction queue overflow, count %0d", instCount);

  // head only moves on a dispatch, flush aside.
  headNeedsReady: assert property (
    @(posedge clk) disable iff (!rstN_i)
    (!flush_i && !instBufferReady_o) |=> (headPtr == $past(headPtr))
  ) else $error("queue head moved with fewer than four entries");

endmodule

// ==== queueRam.sv ====
// circular packet store; enabled write lanes land at consecutive addresses from the base, wrapping at INST_QUEUE.
`timescale 1ns/1ps

module queueRam (
  input  logic                             clk,
  input  logic [fetchPkg::FETCH_WIDTH-1:0] writeEnable_i,  // one bit per lane.
  input  fetchPkg::qPtr_t                  writeAddr_i,    // tail, address of the first enabled lane.
  input  fetchPkg::decodedGroup_t          writeData_i,
  input  fetchPkg::qPtr_t                  readAddr_i,     // head.
  output fetchPkg::dispatchGroup_t         readData_o      // head to head+3.
);

  fetchPkg::decodedInst_t mem [fetchPkg::INST_QUEUE];  // storage, no reset.
  fetchPkg::qPtr_t        laneAddr [fetchPkg::FETCH_WIDTH];  // compacted slot per lane.

  // running sum of enabled lanes below each lane, so holes close up.
  always_comb begin : compactAddr
    fetchPkg::qPtr_t slot;
    slot = writeAddr_i;
    for (int i = 0; i < fetchPkg::FETCH_WIDTH; i++) begin
      laneAddr[i] = slot;
      slot        = slot + fetchPkg::qPtr_t'(writeEnable_i[i]);  // wraps mod 32.
    end
  end

  // eight write ports; enabled lanes never share a slot.
  always_ff @(posedge clk) begin
    for (int i = 0; i < fetchPkg::FETCH_WIDTH; i++) begin
      if (writeEnable_i[i]) begin
        mem[laneAddr[i]] <= writeData_i[i];
      end
    end
  end

  // four combinational read ports.
  for (genvar j = 0; j < fetchPkg::DISPATCH_WIDTH; j++) begin : gRead
    fetchPkg::qPtr_t rdAddr;
    assign rdAddr        = readAddr_i + fetchPkg::qPtr_t'(j);  // wraps past the last entry.
    assign readData_o[j] = mem[rdAddr];
  end

endmodule

// ==== runSim.sh ====
#!/bin/sh
# builds the front end testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module frontEndTb -f sim.f -o frontEndSim

simOut=$(./obj_dir/frontEndSim)
echo "$simOut"

if echo "$simOut" | grep -qx "All tests passed"; then
  exit 0
fi
exit 1

// ==== sim.f ====
fetchPkg.sv
decodeStage.sv
queueRam.sv
instructionBuffer.sv
dispatchStage.sv
frontEnd.sv
frontEndChecker.sv
frontEndTb.sv
